//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_stbuf
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- mem_pkg.sv
// -------------------------------------------------------------------
// memory word geometry and the basic address, byte-enable and data
// types; imported by every block that touches a memory word
// -------------------------------------------------------------------

package mem_pkg;

   // -------------------------------------------------------------------
   // word geometry
   // -------------------------------------------------------------------
   localparam int DATA_WIDTH = 32;              // bits per memory word
   localparam int BYTE_WIDTH = DATA_WIDTH / 8;  // byte lanes per word
   localparam int ADDR_BITS  = 16;              // byte address width

   typedef logic [ADDR_BITS-1:0]  addr_t;
   typedef logic [DATA_WIDTH-1:0] word_t;
   typedef logic [BYTE_WIDTH-1:0] byteen_t;     // one bit per lane

   // -------------------------------------------------------------------
   // access sizes
   // -------------------------------------------------------------------
   typedef enum logic [1:0] {
      size_byte = 2'd0,
      size_half = 2'd1,
      size_word = 2'd2
   } access_size_e;

endpackage

//--- src.f
mem_pkg.sv
stbuf_pkg.sv
store_align.sv
stbuf_commit_track.sv
stbuf_entries.sv
stbuf_fwd.sv
stbuf_top.sv
tb_stbuf.sv

//--- stbuf_commit_track.sv
// -------------------------------------------------------------------
// follows each accepted store from dc3 to dc5 and turns the dc5
// commit decision into per-slot drain or flush marks
// -------------------------------------------------------------------

module stbuf_commit_track #(
   parameter  int DEPTH = 4,
   localparam int PTR_W = $clog2(DEPTH)
) (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             wr_en,        // store accepted in dc3
   input  logic [PTR_W-1:0] wr_ptr,
   input  logic             dual,
   input  logic             commit_dc5,   // 1 commit, 0 flush
   output logic [DEPTH-1:0] drain_mark,
   output logic [DEPTH-1:0] flush_mark
);

   logic             vld_dc4;
   logic             vld_dc5;
   logic [PTR_W-1:0] ptr_dc4;
   logic [PTR_W-1:0] ptr_dc5;
   logic [PTR_W-1:0] ptr1_dc5;
   logic             dual_dc4;
   logic             dual_dc5;
   logic [DEPTH-1:0] slot_dc5;

   // -------------------------------------------------------------------
   // dc4/dc5 pipe
   // -------------------------------------------------------------------
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         vld_dc4 <= 1'b0;
         vld_dc5 <= 1'b0;
      end else begin
         vld_dc4 <= wr_en;
         vld_dc5 <= vld_dc4;
      end
   end

   always_ff @(posedge clk) begin
      ptr_dc4  <= wr_ptr;
      ptr_dc5  <= ptr_dc4;
      dual_dc4 <= dual;
      dual_dc5 <= dual_dc4;
   end

   // -------------------------------------------------------------------
   // slot decode at dc5
   // -------------------------------------------------------------------
   assign ptr1_dc5 = ptr_dc5 + 1'b1;   // wraps with the ring

   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         slot_dc5[i] = vld_dc5 & ((ptr_dc5 == PTR_W'(i)) |
                                  (dual_dc5 & (ptr1_dc5 == PTR_W'(i))));
      end
   end

   assign drain_mark = slot_dc5 & {DEPTH{commit_dc5}};
   assign flush_mark = slot_dc5 & {DEPTH{~commit_dc5}};

   a_commit_known: assert property (@(posedge clk) disable iff (!arst_n)
      vld_dc5 |-> !$isunknown(commit_dc5))
      else $error("commit_dc5 unknown while a store sits in dc5");

endmodule

//--- stbuf_entries.sv
// -------------------------------------------------------------------
// entry ring of the store buffer: write of one or two entries per
// store, drain/flush bookkeeping, in-order drain port and occupancy
// -------------------------------------------------------------------

module stbuf_entries #(
   parameter  int DEPTH = 4,
   localparam int PTR_W = $clog2(DEPTH)
) (
   input  logic                          clk,
   input  logic                          arst_n,
   // write side
   input  logic                          store_valid,
   input  stbuf_pkg::entry_t             lo,
   input  stbuf_pkg::entry_t             hi,
   input  logic                          dual,
   output logic                          store_ready,
   // commit side
   input  logic [DEPTH-1:0]              drain_mark,
   input  logic [DEPTH-1:0]              flush_mark,
   // drain side
   output logic                          drain_valid,
   output stbuf_pkg::drain_t             drain,
   input  logic                          drain_ready,
   // status
   output logic                          stbuf_empty,
   // to commit tracking and forwarding
   output logic                          wr_en,
   output logic [PTR_W-1:0]              wr_ptr,
   output stbuf_pkg::entry_t [DEPTH-1:0] entries,
   output logic [DEPTH-1:0]              live
);
   import stbuf_pkg::*;

   localparam int CNT_W = PTR_W + 1;   // counts 0..DEPTH

   entry_t [DEPTH-1:0] ent_q;
   logic [DEPTH-1:0]   data_vld;
   logic [DEPTH-1:0]   drain_vld;
   logic [DEPTH-1:0]   flush_vld;
   logic [PTR_W-1:0]   rd_ptr;
   logic [PTR_W-1:0]   wr_ptr_p1;
   logic [DEPTH-1:0]   wr_slot;
   logic [DEPTH-1:0]   pop_slot;
   logic [CNT_W-1:0]   numvld;
   logic               head_flushed;
   logic               pop;

   // -------------------------------------------------------------------
   // write
   // -------------------------------------------------------------------
   assign wr_en     = store_valid & store_ready;
   assign wr_ptr_p1 = wr_ptr + 1'b1;

   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         wr_slot[i]  = wr_en & ((wr_ptr == PTR_W'(i)) |
                                (dual & (wr_ptr_p1 == PTR_W'(i))));
         pop_slot[i] = pop & (rd_ptr == PTR_W'(i));
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < DEPTH; i++) begin
         if (wr_slot[i]) begin
            ent_q[i] <= (wr_ptr == PTR_W'(i)) ? lo : hi;   // lo at wr_ptr
         end
      end
   end

   // slot status, cleared when the head leaves
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         data_vld  <= '0;
         drain_vld <= '0;
         flush_vld <= '0;
      end else begin
         data_vld  <= (data_vld | wr_slot) & ~pop_slot;
         drain_vld <= (drain_vld | drain_mark) & ~pop_slot;
         flush_vld <= (flush_vld | flush_mark) & ~pop_slot;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= dual ? wr_ptr + PTR_W'(2) : wr_ptr_p1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // -------------------------------------------------------------------
   // head and occupancy
   // -------------------------------------------------------------------
   assign drain_valid  = drain_vld[rd_ptr];
   assign head_flushed = flush_vld[rd_ptr];   // freed without a beat
   assign pop          = (drain_valid & drain_ready) | head_flushed;
   assign drain        = ent_q[rd_ptr];

   always_comb begin
      numvld = '0;
      for (int i = 0; i < DEPTH; i++) begin
         numvld += CNT_W'(data_vld[i]);
      end
   end

   // room for a dual store
   assign store_ready = (numvld <= CNT_W'(DEPTH - 2));
   assign stbuf_empty = (numvld == '0);

   assign entries = ent_q;
   assign live    = data_vld & ~flush_vld;

   a_mark_on_valid: assert property (@(posedge clk) disable iff (!arst_n)
      ((drain_mark | flush_mark) & ~data_vld) == '0)
      else $error("commit mark on an empty slot");

   a_drain_xor_flush: assert property (@(posedge clk) disable iff (!arst_n)
      (drain_vld & flush_vld) == '0)
      else $error("slot marked for both drain and flush");

   a_empty_no_drain: assert property (@(posedge clk) disable iff (!arst_n)
      stbuf_empty |-> !drain_valid)
      else $error("drain offered from an empty buffer");

endmodule

//--- stbuf_fwd.sv
// -------------------------------------------------------------------
// load forwarding: matches a word address against the live entries
// and merges their bytes, youngest store winning per lane; the
// result is registered and seen one cycle after the request
// -------------------------------------------------------------------

module stbuf_fwd #(
   parameter  int DEPTH = 4,
   localparam int PTR_W = $clog2(DEPTH)
) (
   input  logic                          clk,
   input  logic                          arst_n,
   input  stbuf_pkg::fwd_req_t           req,
   input  stbuf_pkg::entry_t [DEPTH-1:0] entries,
   input  logic [DEPTH-1:0]              live,      // valid and not flushed
   input  logic [PTR_W-1:0]              wr_ptr,    // oldest slot sits here
   output stbuf_pkg::fwd_rsp_t           rsp
);
   import mem_pkg::*;
   import stbuf_pkg::*;

   localparam int OFS_BITS = $clog2(BYTE_WIDTH);

   logic [DEPTH-1:0] hit;
   logic [PTR_W-1:0] idx;
   fwd_rsp_t         rsp_d;

   // -------------------------------------------------------------------
   // address match
   // -------------------------------------------------------------------
   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         hit[i] = req.valid & live[i] &
                  (entries[i].addr[ADDR_BITS-1:OFS_BITS] ==
                   req.addr[ADDR_BITS-1:OFS_BITS]);
      end
   end

   // -------------------------------------------------------------------
   // byte merge
   // -------------------------------------------------------------------
   // walk oldest to youngest so later stores overwrite lanes
   always_comb begin
      rsp_d = '0;
      idx   = wr_ptr;
      for (int k = 0; k < DEPTH; k++) begin
         idx = wr_ptr + PTR_W'(k);
         for (int j = 0; j < BYTE_WIDTH; j++) begin
            if (hit[idx] && entries[idx].byteen[j]) begin
               rsp_d.byteen[j]      = 1'b1;
               rsp_d.data[8*j +: 8] = entries[idx].data[8*j +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rsp <= '0;
      end else begin
         rsp <= rsp_d;
      end
   end

endmodule

//--- stbuf_input.txt
# store buffer stimulus; addr and data in hex, byteen in binary, size 0 byte 1 half 2 word
# T name | S addr size data commit | L addr byteen data | D addr byteen data | R cycles | E
T word_drain
D 0100 1111 11223344
D 0104 1111 55667788
S 0100 2 11223344 1
S 0104 2 55667788 1
E
T half_cross
D 0200 1000 cd000000
D 0204 0001 000000ab
S 0203 1 0000abcd 1
E
T flush_skip
D 0300 1111 cafef00d
S 0300 2 deadbeef 0
S 0300 2 cafef00d 1
E
T fwd_merge
R 30
D 0400 0011 00002211
D 0400 0010 0000bb00
S 0400 1 00002211 1
S 0402 0 000000aa 0
S 0401 0 000000bb 1
L 0400 0011 0000bb11
L 0404 0000 00000000
E
T full_stall
R 20
D 0500 1111 a0a0a0a0
D 0504 1111 b1b1b1b1
D 0508 1111 c2c2c2c2
D 050c 1111 d3d3d3d3
S 0500 2 a0a0a0a0 1
S 0504 2 b1b1b1b1 1
S 0508 2 c2c2c2c2 1
S 050c 2 d3d3d3d3 1
E

//--- stbuf_pkg.sv
// -------------------------------------------------------------------
// traffic structs of the store buffer: store requests, buffer
// entries, drain beats and load forwarding request/response
// -------------------------------------------------------------------

package stbuf_pkg;

   import mem_pkg::*;

   // store from pipeline stage dc3
   typedef struct packed {
      addr_t        addr;   // byte address, any alignment
      access_size_e size;
      word_t        data;   // right-justified
   } store_req_t;

   // one slot of the buffer, always word aligned
   typedef struct packed {
      addr_t   addr;        // word address, low bits zero
      byteen_t byteen;
      word_t   data;        // bytes sit in their own lanes
   } entry_t;

   // head entry as offered to memory
   typedef entry_t drain_t;

   // load lookup, word address
   typedef struct packed {
      logic  valid;
      addr_t addr;
   } fwd_req_t;

   // forwarded bytes, unused lanes read as zero
   typedef struct packed {
      byteen_t byteen;
      word_t   data;
   } fwd_rsp_t;

endpackage

//--- stbuf_top.sv
// -------------------------------------------------------------------
// store buffer top: alignment, commit tracking, entry ring and load
// forwarding; sets the buffer depth for all blocks
// -------------------------------------------------------------------

module stbuf_top (
   input  logic                  clk,
   input  logic                  arst_n,
   // stores from dc3
   input  logic                  store_valid,
   output logic                  store_ready,
   input  stbuf_pkg::store_req_t store_req,
   input  logic                  commit_dc5,
   // drain to memory
   output logic                  drain_valid,
   input  logic                  drain_ready,
   output stbuf_pkg::drain_t     drain,
   output logic                  stbuf_empty,
   // load forwarding
   input  stbuf_pkg::fwd_req_t   fwd_req,
   output stbuf_pkg::fwd_rsp_t   fwd_rsp
);
   import stbuf_pkg::*;

   localparam int DEPTH = 4;
   localparam int PTR_W = $clog2(DEPTH);

   entry_t             lo;
   entry_t             hi;
   logic               dual;
   logic               wr_en;
   logic [PTR_W-1:0]   wr_ptr;
   logic [DEPTH-1:0]   drain_mark;
   logic [DEPTH-1:0]   flush_mark;
   entry_t [DEPTH-1:0] entries;
   logic [DEPTH-1:0]   live;

   store_align u_align (
      .req  (store_req),
      .lo   (lo),
      .hi   (hi),
      .dual (dual)
   );

   stbuf_commit_track #(.DEPTH(DEPTH)) u_commit (
      .clk        (clk),
      .arst_n     (arst_n),
      .wr_en      (wr_en),
      .wr_ptr     (wr_ptr),
      .dual       (dual),
      .commit_dc5 (commit_dc5),
      .drain_mark (drain_mark),
      .flush_mark (flush_mark)
   );

   stbuf_entries #(.DEPTH(DEPTH)) u_entries (
      .clk         (clk),
      .arst_n      (arst_n),
      .store_valid (store_valid),
      .lo          (lo),
      .hi          (hi),
      .dual        (dual),
      .store_ready (store_ready),
      .drain_mark  (drain_mark),
      .flush_mark  (flush_mark),
      .drain_valid (drain_valid),
      .drain       (drain),
      .drain_ready (drain_ready),
      .stbuf_empty (stbuf_empty),
      .wr_en       (wr_en),
      .wr_ptr      (wr_ptr),
      .entries     (entries),
      .live        (live)
   );

   stbuf_fwd #(.DEPTH(DEPTH)) u_fwd (
      .clk     (clk),
      .arst_n  (arst_n),
      .req     (fwd_req),
      .entries (entries),
      .live    (live),
      .wr_ptr  (wr_ptr),
      .rsp     (fwd_rsp)
   );

endmodule

//--- store_align.sv
// -------------------------------------------------------------------
// splits a store into one or two word-aligned entries; the low word
// always comes first, the high word only when the store crosses a
// word boundary (dual)
// -------------------------------------------------------------------

module store_align (
   input  stbuf_pkg::store_req_t req,
   output stbuf_pkg::entry_t     lo,
   output stbuf_pkg::entry_t     hi,
   output logic                  dual
);
   import mem_pkg::*;

   localparam int OFS_BITS = $clog2(BYTE_WIDTH);

   logic [2*BYTE_WIDTH-1:0] mask_base;
   logic [2*BYTE_WIDTH-1:0] mask_ext;    // two-word byte window
   logic [2*DATA_WIDTH-1:0] data_ext;
   logic [2*DATA_WIDTH-1:0] data_clean;
   logic [OFS_BITS-1:0]     offset;
   addr_t                   word_addr;

   assign offset    = req.addr[OFS_BITS-1:0];
   assign word_addr = {req.addr[ADDR_BITS-1:OFS_BITS], {OFS_BITS{1'b0}}};

   always_comb begin
      case (req.size)
         size_byte: mask_base = 8'b0000_0001;
         size_half: mask_base = 8'b0000_0011;
         default:   mask_base = 8'b0000_1111;   // word
      endcase
   end

   assign mask_ext = mask_base << offset;
   assign data_ext = {{DATA_WIDTH{1'b0}}, req.data} << {offset, 3'b000};

   // drop bytes beyond the access size
   for (genvar j = 0; j < 2*BYTE_WIDTH; j++) begin : g_lane
      assign data_clean[8*j +: 8] = data_ext[8*j +: 8] & {8{mask_ext[j]}};
   end

   assign lo.addr   = word_addr;
   assign lo.byteen = mask_ext[BYTE_WIDTH-1:0];
   assign lo.data   = data_clean[DATA_WIDTH-1:0];

   assign hi.addr   = word_addr + ADDR_BITS'(BYTE_WIDTH);  // next word
   assign hi.byteen = mask_ext[2*BYTE_WIDTH-1:BYTE_WIDTH];
   assign hi.data   = data_clean[2*DATA_WIDTH-1:DATA_WIDTH];

   assign dual = |mask_ext[2*BYTE_WIDTH-1:BYTE_WIDTH];

endmodule

//--- tb_stbuf.sv
// ----------------------------------------------------------------------
// testbench for the store buffer; runs the stores, loads and expected
// drain beats of stbuf_input.txt and tracks occupancy with a small
// model of the entry ring (ready, empty and head state every cycle)
// ----------------------------------------------------------------------

module tb_stbuf;
   import mem_pkg::*;
   import stbuf_pkg::*;

   localparam int DEPTH     = 4;     // as set in the DUT top
   localparam int ST_NONE   = 0;
   localparam int ST_PEND   = 1;
   localparam int ST_COMMIT = 2;
   localparam int ST_FLUSH  = 3;

   // one store on its way from dc3 to dc5
   typedef struct packed {
      logic       vld;
      logic       commit;
      logic [1:0] n;      // entries taken
      int         id;     // sequence number of its first entry
   } inflight_t;

   logic       clk;
   logic       arst_n;
   logic       store_valid;
   logic       store_ready;
   store_req_t store_req;
   logic       commit_dc5;
   logic       drain_valid;
   logic       drain_ready;
   drain_t     drain;
   logic       stbuf_empty;
   fwd_req_t   fwd_req;
   fwd_rsp_t   fwd_rsp;

   drain_t     exp_q[$];
   inflight_t  stage_a;          // dc4
   inflight_t  stage_b;          // dc5
   int         slot_st[64];
   int         wr_seq;
   int         rd_seq;
   logic       cur_commit;
   logic [1:0] cur_n;
   int         hold_cnt;
   int         errors;
   int         checks;
   int         cycles;
   int         limit;

   stbuf_top dut0 (.*);

   initial clk = 1'b0;
   always #2 clk = ~clk;

   task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %0t: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   // a store spills into the next word when it runs past byte 3
   function automatic logic [1:0] entries_for(input logic [15:0] addr, input int size);
      int last;
      last = int'(addr[1:0]) + (1 << size);
      return (last > 4) ? 2'd2 : 2'd1;
   endfunction

   task automatic step();
      @(posedge clk);
      #1;
      drain_ready = (hold_cnt == 0);
      if (hold_cnt > 0) hold_cnt--;
   endtask

   task automatic report_test(input string name, input int err_before);
      $display("test %s finished with %0d errors", name, errors - err_before);
   endtask

   // ----------------------------------------------------------------------
   // timeout and commit driver
   // ----------------------------------------------------------------------
   always @(posedge clk) begin
      cycles++;
      if (limit > 0 && cycles > limit) begin
         $display("run timed out after %0d cycles", cycles);
         $display("Errors found");
         $finish;
      end
   end

   always @(posedge clk) begin
      #1;
      commit_dc5 = stage_b.vld ? stage_b.commit : 1'b0;   // held over dc5
   end

   // ----------------------------------------------------------------------
   // ring model and drain monitor, sampled mid-cycle
   // ----------------------------------------------------------------------
   always @(negedge clk) begin
      int     head_st;
      drain_t beat;
      if (arst_n) begin
         head_st = (rd_seq != wr_seq) ? slot_st[rd_seq % 64] : ST_NONE;
         check(64'(store_ready), 64'((wr_seq - rd_seq) <= DEPTH - 2), "store_ready");
         check(64'(stbuf_empty), 64'(wr_seq == rd_seq), "stbuf_empty");
         check(64'(drain_valid), 64'(head_st == ST_COMMIT), "drain_valid");
         if (drain_valid && drain_ready) begin
            if (exp_q.size() == 0) begin
               errors++;
               $display("unexpected drain beat at time %0t for address %h", $time, drain.addr);
            end else begin
               beat = exp_q.pop_front();
               check(64'(drain), 64'(beat), "drain beat");
            end
         end
         if ((head_st == ST_COMMIT && drain_ready) || head_st == ST_FLUSH) rd_seq++;
         // marks of the store in dc5 land at the coming edge
         if (stage_b.vld) begin
            for (int k = 0; k < int'(stage_b.n); k++) begin
               slot_st[(stage_b.id + k) % 64] = stage_b.commit ? ST_COMMIT : ST_FLUSH;
            end
         end
         stage_b = stage_a;
         stage_a = '0;
         if (store_valid && store_ready) begin
            stage_a = '{vld: 1'b1, commit: cur_commit, n: cur_n, id: wr_seq};
            for (int k = 0; k < int'(cur_n); k++) slot_st[(wr_seq + k) % 64] = ST_PEND;
            wr_seq += int'(cur_n);
         end
      end
   end

   // ----------------------------------------------------------------------
   // file reader and sequencer
   // ----------------------------------------------------------------------
   initial begin
      string       lines[$];
      string       line;
      string       tag;
      string       name;
      int          fd;
      int          rc;
      int          tests;
      int          test_err;
      int          sz;
      int          c;
      int          n;
      logic [15:0] a;
      logic [3:0]  be;
      logic [31:0] d;
      drain_t      beat;
      arst_n = 1'b0;
      store_valid = 1'b0;
      store_req = '0;
      commit_dc5 = 1'b0;
      drain_ready = 1'b1;
      fwd_req = '0;
      stage_a = '0;
      stage_b = '0;
      cur_commit = 1'b0;
      cur_n = 2'd1;
      {wr_seq, rd_seq, hold_cnt, errors, checks, cycles, limit, tests, test_err} = '0;
      name = "";
      fd = $fopen("stbuf_input.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("cannot open the stimulus file stbuf_input.txt");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            rc = $fgets(line, fd);
            if (line.len() > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
               lines.push_back(line);
            end
         end
         $fclose(fd);
      end
      limit = 20 * lines.size() + 100;
      repeat (4) @(posedge clk);
      #1 arst_n = 1'b1;
      step();
      foreach (lines[i]) begin
         line = lines[i];
         rc = $sscanf(line, "%s", tag);
         if (tag == "T") begin
            if (name != "") report_test(name, test_err);
            rc = $sscanf(line, "%s %s", tag, name);
            test_err = errors;
            tests++;
         end else if (tag == "S") begin
            rc = $sscanf(line, "%s %h %d %h %d", tag, a, sz, d, c);
            store_req.addr = a;
            store_req.size = access_size_e'(sz);
            store_req.data = d;
            cur_commit = (c != 0);
            cur_n = entries_for(a, sz);
            store_valid = 1'b1;
            @(negedge clk);
            while (!store_ready) begin
               step();
               @(negedge clk);
            end
            step();
            store_valid = 1'b0;
         end else if (tag == "L") begin
            rc = $sscanf(line, "%s %h %b %h", tag, a, be, d);
            step();                  // earlier stores reach dc5 first
            step();
            fwd_req = '{valid: 1'b1, addr: a};
            step();
            fwd_req.valid = 1'b0;
            @(negedge clk);
            check(64'(fwd_rsp.byteen), 64'(be), "forward byteen");
            check(64'(fwd_rsp.data), 64'(d), "forward data");
            step();
         end else if (tag == "D") begin
            rc = $sscanf(line, "%s %h %b %h", tag, a, be, d);
            beat.addr = a;
            beat.byteen = be;
            beat.data = d;
            exp_q.push_back(beat);
         end else if (tag == "R") begin
            rc = $sscanf(line, "%s %d", tag, n);
            hold_cnt = n;
         end else if (tag == "E") begin
            n = 0;
            while ((!stbuf_empty || exp_q.size() != 0) && n < 100) begin
               step();
               n++;
            end
            check(64'(stbuf_empty), 64'(1), "stbuf_empty at end of test");
            if (exp_q.size() != 0) begin
               errors++;
               $display("%0d expected drain beats never appeared", exp_q.size());
               exp_q.delete();
            end
         end else begin
            errors++;
            $display("unknown line in the stimulus file: %s", line);
         end
      end
      if (name != "") report_test(name, test_err);
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule
